//--- hdl/soc_bus_pkg.sv
package soc_bus_pkg;

   // Bus widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // Follower count and index width
   localparam int N_FOLLOWERS = 2;
   localparam int SEL_W       = 1;

   // Follower word-address widths
   localparam int RAM_AW = 8;
   localparam int REG_AW = 2;

   // Address map, as values of the sel field
   localparam int RAM_SEL = 0;
   localparam int REG_SEL = 1;

   // Register block: index of the read-only write counter, scratch below it
   localparam int REG_CNT = 3;

   // One bus address seen either as a raw word or as its decoded fields
   typedef union packed {
      logic [ADDR_W-1:0] raw;
      struct packed {
         logic [SEL_W-1:0]                  sel;
         logic [ADDR_W-SEL_W-RAM_AW-3:0]    spare;
         logic [RAM_AW-1:0]                 word;
         logic [1:0]                        byte_off;
      } fld;
   } bus_addr_u;

endpackage

//--- hdl/iob_bus_arbiter.sv
module iob_bus_arbiter (
   input  logic                            clk_i,
   input  logic                            rst_i,

   // Requester 0
   input  logic                            m0_avalid_i,
   input  logic [soc_bus_pkg::ADDR_W-1:0]  m0_addr_i,
   input  logic [soc_bus_pkg::DATA_W-1:0]  m0_wdata_i,
   input  logic [soc_bus_pkg::STRB_W-1:0]  m0_wstrb_i,
   output logic [soc_bus_pkg::DATA_W-1:0]  m0_rdata_o,
   output logic                            m0_rvalid_o,
   output logic                            m0_ready_o,

   // Requester 1
   input  logic                            m1_avalid_i,
   input  logic [soc_bus_pkg::ADDR_W-1:0]  m1_addr_i,
   input  logic [soc_bus_pkg::DATA_W-1:0]  m1_wdata_i,
   input  logic [soc_bus_pkg::STRB_W-1:0]  m1_wstrb_i,
   output logic [soc_bus_pkg::DATA_W-1:0]  m1_rdata_o,
   output logic                            m1_rvalid_o,
   output logic                            m1_ready_o,

   // Shared bus
   output logic                            s_avalid_o,
   output logic [soc_bus_pkg::ADDR_W-1:0]  s_addr_o,
   output logic [soc_bus_pkg::DATA_W-1:0]  s_wdata_o,
   output logic [soc_bus_pkg::STRB_W-1:0]  s_wstrb_o,
   input  logic [soc_bus_pkg::DATA_W-1:0]  s_rdata_i,
   input  logic                            s_rvalid_i,
   input  logic                            s_ready_i
);

   logic last_q;   // requester served last
   logic lock_q;   // read accepted, response still pending
   logic held_q;   // grant given but request not yet accepted
   logic own_q;    // holder of the grant or of the pending read
   logic gnt;
   logic accept;

   // A held grant wins; on a tie the requester not served last wins
   always_comb begin
      if (held_q) begin
         gnt = own_q;
      end else if (m0_avalid_i && m1_avalid_i) begin
         gnt = ~last_q;
      end else begin
         gnt = m1_avalid_i;
      end
   end

   // Nothing is passed while a read is outstanding
   assign s_avalid_o = ~lock_q & (gnt ? m1_avalid_i : m0_avalid_i);
   assign s_addr_o   = gnt ? m1_addr_i : m0_addr_i;
   assign s_wdata_o  = gnt ? m1_wdata_i : m0_wdata_i;
   assign s_wstrb_o  = gnt ? m1_wstrb_i : m0_wstrb_i;

   assign accept     = s_avalid_o & s_ready_i;
   assign m0_ready_o = accept & ~gnt;
   assign m1_ready_o = accept & gnt;

   // Response goes back to the owner of the locked read only
   assign m0_rvalid_o = s_rvalid_i & lock_q & ~own_q;
   assign m1_rvalid_o = s_rvalid_i & lock_q & own_q;
   assign m0_rdata_o  = (lock_q && !own_q) ? s_rdata_i : '0;
   assign m1_rdata_o  = (lock_q && own_q) ? s_rdata_i : '0;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         last_q <= 1'b1;   // so that requester 0 wins the first tie
         lock_q <= 1'b0;
         held_q <= 1'b0;
         own_q  <= 1'b0;
      end else begin
         if (s_avalid_o) begin
            own_q  <= gnt;
            held_q <= ~s_ready_i;
         end
         if (accept) begin
            last_q <= gnt;
            if (s_wstrb_o == '0) begin
               lock_q <= 1'b1;
            end
         end else if (s_rvalid_i) begin
            lock_q <= 1'b0;
         end
      end
   end

endmodule

//--- hdl/iob_bus_demux.sv
module iob_bus_demux #(
   parameter int N = 2
) (
   input  logic                                 clk_i,
   input  logic                                 rst_i,

   // Master side
   input  logic                                 m_avalid_i,
   input  logic [soc_bus_pkg::ADDR_W-1:0]       m_addr_i,
   input  logic [soc_bus_pkg::DATA_W-1:0]       m_wdata_i,
   input  logic [soc_bus_pkg::STRB_W-1:0]       m_wstrb_i,
   output logic [soc_bus_pkg::DATA_W-1:0]       m_rdata_o,
   output logic                                 m_rvalid_o,
   output logic                                 m_ready_o,

   // Follower side, one slice per follower
   output logic [N-1:0]                         f_avalid_o,
   output logic [N*soc_bus_pkg::ADDR_W-1:0]     f_addr_o,
   output logic [N*soc_bus_pkg::DATA_W-1:0]     f_wdata_o,
   output logic [N*soc_bus_pkg::STRB_W-1:0]     f_wstrb_o,
   input  logic [N*soc_bus_pkg::DATA_W-1:0]     f_rdata_i,
   input  logic [N-1:0]                         f_rvalid_i,
   input  logic [N-1:0]                         f_ready_i
);

   // Bits needed to address all followers
   localparam int SEL_W = $clog2(N);

   soc_bus_pkg::bus_addr_u addr_u;
   logic [SEL_W-1:0]       sel_live;
   logic [SEL_W-1:0]       sel_q;

   assign addr_u   = m_addr_i;
   assign sel_live = SEL_W'(addr_u.fld.sel);

   // Only the addressed follower sees avalid
   for (genvar i = 0; i < N; i++) begin : g_avalid
      assign f_avalid_o[i] = m_avalid_i && (sel_live == SEL_W'(i));
   end

   // Request payload is broadcast
   assign f_addr_o  = {N{m_addr_i}};
   assign f_wdata_o = {N{m_wdata_i}};
   assign f_wstrb_o = {N{m_wstrb_i}};

   // Ready belongs to the current request
   assign m_ready_o = f_ready_i[sel_live];

   // Remember who was accepted, the response arrives later
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sel_q <= '0;
      end else if (m_avalid_i && m_ready_o) begin
         sel_q <= sel_live;
      end
   end

   assign m_rdata_o  = f_rdata_i[sel_q*soc_bus_pkg::DATA_W +: soc_bus_pkg::DATA_W];
   assign m_rvalid_o = f_rvalid_i[sel_q];

endmodule

//--- hdl/iob_ram_sp.sv
module iob_ram_sp (
   input  logic                            clk_i,
   input  logic                            rst_i,
   input  logic                            avalid_i,
   input  logic [soc_bus_pkg::ADDR_W-1:0]  addr_i,
   input  logic [soc_bus_pkg::DATA_W-1:0]  wdata_i,
   input  logic [soc_bus_pkg::STRB_W-1:0]  wstrb_i,
   output logic [soc_bus_pkg::DATA_W-1:0]  rdata_o,
   output logic                            rvalid_o,
   output logic                            ready_o
);

   logic [soc_bus_pkg::DATA_W-1:0] mem [2**soc_bus_pkg::RAM_AW];
   soc_bus_pkg::bus_addr_u         addr_u;
   logic                           rvalid_q;

   assign addr_u  = addr_i;
   assign ready_o = 1'b1;   // never stalls

   // Byte-masked write, registered read
   always_ff @(posedge clk_i) begin
      if (avalid_i) begin
         if (wstrb_i != '0) begin
            for (int b = 0; b < soc_bus_pkg::STRB_W; b++) begin
               if (wstrb_i[b]) begin
                  mem[addr_u.fld.word][b*8 +: 8] <= wdata_i[b*8 +: 8];
               end
            end
         end else begin
            rdata_o <= mem[addr_u.fld.word];
         end
      end
   end

   // Read response one cycle after acceptance
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= avalid_i && (wstrb_i == '0);
      end
   end

   assign rvalid_o = rvalid_q;

endmodule

//--- hdl/iob_regs_ws.sv
module iob_regs_ws (
   input  logic                            clk_i,
   input  logic                            rst_i,
   input  logic                            avalid_i,
   input  logic [soc_bus_pkg::ADDR_W-1:0]  addr_i,
   input  logic [soc_bus_pkg::DATA_W-1:0]  wdata_i,
   input  logic [soc_bus_pkg::STRB_W-1:0]  wstrb_i,
   output logic [soc_bus_pkg::DATA_W-1:0]  rdata_o,
   output logic                            rvalid_o,
   output logic                            ready_o
);

   soc_bus_pkg::bus_addr_u          addr_u;
   logic [soc_bus_pkg::REG_AW-1:0]  idx;
   logic                            ws_q;
   logic                            accept;
   logic                            is_wr;
   logic [soc_bus_pkg::DATA_W-1:0]  scratch_q [soc_bus_pkg::REG_CNT];
   logic [soc_bus_pkg::DATA_W-1:0]  wr_cnt_q;
   logic [soc_bus_pkg::DATA_W-1:0]  rd_word;
   logic                            rvalid_q;

   assign addr_u = addr_i;
   assign idx    = addr_u.fld.word[soc_bus_pkg::REG_AW-1:0];
   assign is_wr  = |wstrb_i;

   // One wait state: ready only in the second cycle of a held avalid
   assign ready_o = ws_q;
   assign accept  = avalid_i & ws_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ws_q <= 1'b0;
      end else if (accept) begin
         ws_q <= 1'b0;
      end else if (avalid_i) begin
         ws_q <= 1'b1;
      end
   end

   // Scratch registers and the write counter
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         scratch_q <= '{default: '0};
         wr_cnt_q  <= '0;
      end else if (accept && is_wr) begin
         wr_cnt_q <= wr_cnt_q + 1'b1;
         if (idx != soc_bus_pkg::REG_AW'(soc_bus_pkg::REG_CNT)) begin
            for (int b = 0; b < soc_bus_pkg::STRB_W; b++) begin
               if (wstrb_i[b]) begin
                  scratch_q[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
               end
            end
         end
      end
   end

   always_comb begin
      if (idx == soc_bus_pkg::REG_AW'(soc_bus_pkg::REG_CNT)) begin
         rd_word = wr_cnt_q;
      end else begin
         rd_word = scratch_q[idx];
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept && !is_wr) begin
         rdata_o <= rd_word;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= accept & ~is_wr;
      end
   end

   assign rvalid_o = rvalid_q;

endmodule

//--- hdl/iob_soc_bus.sv
module iob_soc_bus (
   input  logic                            clk_i,
   input  logic                            rst_i,

   input  logic                            m0_avalid_i,
   input  logic [soc_bus_pkg::ADDR_W-1:0]  m0_addr_i,
   input  logic [soc_bus_pkg::DATA_W-1:0]  m0_wdata_i,
   input  logic [soc_bus_pkg::STRB_W-1:0]  m0_wstrb_i,
   output logic [soc_bus_pkg::DATA_W-1:0]  m0_rdata_o,
   output logic                            m0_rvalid_o,
   output logic                            m0_ready_o,

   input  logic                            m1_avalid_i,
   input  logic [soc_bus_pkg::ADDR_W-1:0]  m1_addr_i,
   input  logic [soc_bus_pkg::DATA_W-1:0]  m1_wdata_i,
   input  logic [soc_bus_pkg::STRB_W-1:0]  m1_wstrb_i,
   output logic [soc_bus_pkg::DATA_W-1:0]  m1_rdata_o,
   output logic                            m1_rvalid_o,
   output logic                            m1_ready_o
);

   localparam int NF = soc_bus_pkg::N_FOLLOWERS;
   localparam int AW = soc_bus_pkg::ADDR_W;
   localparam int DW = soc_bus_pkg::DATA_W;
   localparam int SW = soc_bus_pkg::STRB_W;
   localparam int RS = soc_bus_pkg::RAM_SEL;
   localparam int GS = soc_bus_pkg::REG_SEL;

   // Shared bus between arbiter and demux
   logic          s_avalid;
   logic [AW-1:0] s_addr;
   logic [DW-1:0] s_wdata;
   logic [SW-1:0] s_wstrb;
   logic [DW-1:0] s_rdata;
   logic          s_rvalid;
   logic          s_ready;

   // Follower vectors
   logic [NF-1:0]    f_avalid;
   logic [NF*AW-1:0] f_addr;
   logic [NF*DW-1:0] f_wdata;
   logic [NF*SW-1:0] f_wstrb;
   logic [NF*DW-1:0] f_rdata;
   logic [NF-1:0]    f_rvalid;
   logic [NF-1:0]    f_ready;

   iob_bus_arbiter arb (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .m0_avalid_i (m0_avalid_i),
      .m0_addr_i   (m0_addr_i),
      .m0_wdata_i  (m0_wdata_i),
      .m0_wstrb_i  (m0_wstrb_i),
      .m0_rdata_o  (m0_rdata_o),
      .m0_rvalid_o (m0_rvalid_o),
      .m0_ready_o  (m0_ready_o),
      .m1_avalid_i (m1_avalid_i),
      .m1_addr_i   (m1_addr_i),
      .m1_wdata_i  (m1_wdata_i),
      .m1_wstrb_i  (m1_wstrb_i),
      .m1_rdata_o  (m1_rdata_o),
      .m1_rvalid_o (m1_rvalid_o),
      .m1_ready_o  (m1_ready_o),
      .s_avalid_o  (s_avalid),
      .s_addr_o    (s_addr),
      .s_wdata_o   (s_wdata),
      .s_wstrb_o   (s_wstrb),
      .s_rdata_i   (s_rdata),
      .s_rvalid_i  (s_rvalid),
      .s_ready_i   (s_ready)
   );

   iob_bus_demux #(
      .N (NF)
   ) demux (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .m_avalid_i (s_avalid),
      .m_addr_i   (s_addr),
      .m_wdata_i  (s_wdata),
      .m_wstrb_i  (s_wstrb),
      .m_rdata_o  (s_rdata),
      .m_rvalid_o (s_rvalid),
      .m_ready_o  (s_ready),
      .f_avalid_o (f_avalid),
      .f_addr_o   (f_addr),
      .f_wdata_o  (f_wdata),
      .f_wstrb_o  (f_wstrb),
      .f_rdata_i  (f_rdata),
      .f_rvalid_i (f_rvalid),
      .f_ready_i  (f_ready)
   );

   iob_ram_sp ram (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .avalid_i (f_avalid[RS]),
      .addr_i   (f_addr[RS*AW +: AW]),
      .wdata_i  (f_wdata[RS*DW +: DW]),
      .wstrb_i  (f_wstrb[RS*SW +: SW]),
      .rdata_o  (f_rdata[RS*DW +: DW]),
      .rvalid_o (f_rvalid[RS]),
      .ready_o  (f_ready[RS])
   );

   iob_regs_ws regs (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .avalid_i (f_avalid[GS]),
      .addr_i   (f_addr[GS*AW +: AW]),
      .wdata_i  (f_wdata[GS*DW +: DW]),
      .wstrb_i  (f_wstrb[GS*SW +: SW]),
      .rdata_o  (f_rdata[GS*DW +: DW]),
      .rvalid_o (f_rvalid[GS]),
      .ready_o  (f_ready[GS])
   );

endmodule

//--- verif/iob_bus_chk.sv
module iob_bus_chk (
   input logic                           clk_i,
   input logic                           rst_i,
   input logic                           m0_avalid_i,
   input logic [soc_bus_pkg::STRB_W-1:0] m0_wstrb_i,
   input logic                           m0_ready_i,
   input logic                           m0_rvalid_i,
   input logic                           m1_avalid_i,
   input logic [soc_bus_pkg::STRB_W-1:0] m1_wstrb_i,
   input logic                           m1_ready_i,
   input logic                           m1_rvalid_i
);

   int fail_cnt = 0;

   // Requests stay up until accepted
   a_m0_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      m0_avalid_i && !m0_ready_i |=> m0_avalid_i)
      else begin
         $error("requester 0 dropped avalid before ready");
         fail_cnt++;
      end

   a_m1_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      m1_avalid_i && !m1_ready_i |=> m1_avalid_i)
      else begin
         $error("requester 1 dropped avalid before ready");
         fail_cnt++;
      end

   a_one_grant: assert property (@(posedge clk_i) disable iff (rst_i)
      !(m0_ready_i && m1_ready_i))
      else begin
         $error("both requesters accepted in one cycle");
         fail_cnt++;
      end

   // Response only right after a read acceptance at the same requester
   a_m0_rsp: assert property (@(posedge clk_i) disable iff (rst_i)
      m0_rvalid_i |-> $past(m0_avalid_i && m0_ready_i && m0_wstrb_i == '0))
      else begin
         $error("requester 0 rvalid without a preceding read");
         fail_cnt++;
      end

   a_m1_rsp: assert property (@(posedge clk_i) disable iff (rst_i)
      m1_rvalid_i |-> $past(m1_avalid_i && m1_ready_i && m1_wstrb_i == '0))
      else begin
         $error("requester 1 rvalid without a preceding read");
         fail_cnt++;
      end

endmodule

bind iob_soc_bus iob_bus_chk chk (
   .clk_i       (clk_i),
   .rst_i       (rst_i),
   .m0_avalid_i (m0_avalid_i),
   .m0_wstrb_i  (m0_wstrb_i),
   .m0_ready_i  (m0_ready_o),
   .m0_rvalid_i (m0_rvalid_o),
   .m1_avalid_i (m1_avalid_i),
   .m1_wstrb_i  (m1_wstrb_i),
   .m1_ready_i  (m1_ready_o),
   .m1_rvalid_i (m1_rvalid_o)
);

//--- verif/tb_iob_soc_bus.sv
module tb_iob_soc_bus;

   localparam int CLK_P    = 40;
   localparam int RST_CYC  = 10;
   localparam int STIM_DLY = 5;
   localparam int N_REQ    = 200;
   localparam int N_DIRECT = 4;
   // Per request at most idle gap, arbitration with wait state, and response
   localparam int TIMEOUT  = (2 * N_REQ + N_DIRECT) * (4 + 4 + 2) * CLK_P + RST_CYC * CLK_P;

   logic                           clk_i;
   logic                           rst_i;
   logic                           req_avalid [2];
   logic [soc_bus_pkg::ADDR_W-1:0] req_addr   [2];
   logic [soc_bus_pkg::DATA_W-1:0] req_wdata  [2];
   logic [soc_bus_pkg::STRB_W-1:0] req_wstrb  [2];
   logic [soc_bus_pkg::DATA_W-1:0] rsp_rdata  [2];
   logic                           rsp_rvalid [2];
   logic                           rsp_ready  [2];

   // Reference model and response tracking
   logic [soc_bus_pkg::DATA_W-1:0] ram_m     [2**soc_bus_pkg::RAM_AW];
   logic [soc_bus_pkg::DATA_W-1:0] ram_mask  [2**soc_bus_pkg::RAM_AW];
   logic [soc_bus_pkg::DATA_W-1:0] scratch_m [soc_bus_pkg::REG_CNT];
   logic [soc_bus_pkg::DATA_W-1:0] wr_cnt;
   logic [soc_bus_pkg::DATA_W-1:0] exp_data  [2];
   logic [soc_bus_pkg::DATA_W-1:0] exp_mask  [2];
   logic [soc_bus_pkg::ADDR_W-1:0] exp_addr  [2];
   bit                             pending   [2] = '{0, 0};
   int                             due       [2];
   int                             skip_cnt  [2] = '{0, 0};
   bit                             was_busy;
   int                             cyc        = 0;
   int                             data_errs  = 0;
   int                             proto_errs = 0;

   iob_soc_bus uut (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .m0_avalid_i (req_avalid[0]),
      .m0_addr_i   (req_addr[0]),
      .m0_wdata_i  (req_wdata[0]),
      .m0_wstrb_i  (req_wstrb[0]),
      .m0_rdata_o  (rsp_rdata[0]),
      .m0_rvalid_o (rsp_rvalid[0]),
      .m0_ready_o  (rsp_ready[0]),
      .m1_avalid_i (req_avalid[1]),
      .m1_addr_i   (req_addr[1]),
      .m1_wdata_i  (req_wdata[1]),
      .m1_wstrb_i  (req_wstrb[1]),
      .m1_rdata_o  (rsp_rdata[1]),
      .m1_rvalid_o (rsp_rvalid[1]),
      .m1_ready_o  (rsp_ready[1])
   );

   always #(CLK_P / 2) clk_i = ~clk_i;

   task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         data_errs++;
         $display("** Error at time %0t: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic flag_protocol(input string what);
      proto_errs++;
      $display("Protocol error at time %0t: %s", $time, what);
   endtask

   // Holds the request until ready, then waits for the read response
   task automatic drive_request(input int r, input logic [15:0] addr, input logic [31:0] wdata,
                                input logic [3:0] wstrb);
      req_avalid[r] = 1'b1;
      req_addr[r]   = addr;
      req_wdata[r]  = wdata;
      req_wstrb[r]  = wstrb;
      do @(negedge clk_i); while (!rsp_ready[r]);
      @(posedge clk_i);
      #STIM_DLY;
      req_avalid[r] = 1'b0;
      if (wstrb == '0) begin
         do @(negedge clk_i); while (!rsp_rvalid[r]);
         @(posedge clk_i);
         #STIM_DLY;
      end
   endtask

   task automatic run_requester(input int r, input int n);
      soc_bus_pkg::bus_addr_u a;
      logic [3:0]             strb;
      for (int k = 0; k < n; k++) begin
         repeat ($urandom_range(3)) begin
            @(posedge clk_i);
            #STIM_DLY;
         end
         a.raw     = '0;
         a.fld.sel = $urandom_range(1);
         // Only a few RAM words, so reads often hit written data
         if (a.fld.sel == soc_bus_pkg::REG_SEL) begin
            a.fld.word = $urandom_range(3);
         end else begin
            a.fld.word = $urandom_range(15);
         end
         strb = $urandom_range(1) ? 4'($urandom_range(15, 1)) : 4'h0;
         drive_request(r, a.raw, $urandom, strb);
      end
   endtask

   // Model update at acceptance, and the expected read response
   task automatic apply_accept(input int r);
      soc_bus_pkg::bus_addr_u a;
      logic [31:0]            bmask;
      logic [1:0]             idx;
      a.raw = req_addr[r];
      idx   = a.fld.word[1:0];
      for (int b = 0; b < 4; b++) begin
         bmask[b*8 +: 8] = {8{req_wstrb[r][b]}};
      end
      if (req_wstrb[r] != '0) begin
         if (a.fld.sel == soc_bus_pkg::RAM_SEL) begin
            ram_m[a.fld.word]    = (ram_m[a.fld.word] & ~bmask) | (req_wdata[r] & bmask);
            ram_mask[a.fld.word] = ram_mask[a.fld.word] | bmask;
         end else begin
            wr_cnt = wr_cnt + 1;
            if (idx != soc_bus_pkg::REG_CNT) begin
               scratch_m[idx] = (scratch_m[idx] & ~bmask) | (req_wdata[r] & bmask);
            end
         end
      end else begin
         pending[r]  = 1'b1;
         due[r]      = cyc + 1;
         exp_addr[r] = a.raw;
         exp_mask[r] = (a.fld.sel == soc_bus_pkg::RAM_SEL) ? ram_mask[a.fld.word] : '1;
         if (a.fld.sel == soc_bus_pkg::RAM_SEL) begin
            exp_data[r] = ram_m[a.fld.word];
         end else begin
            exp_data[r] = (idx == soc_bus_pkg::REG_CNT) ? wr_cnt : scratch_m[idx];
         end
      end
   endtask

   task automatic check_response(input int r);
      if (rsp_rvalid[r]) begin
         if (!pending[r]) begin
            flag_protocol($sformatf("requester %0d got rvalid with no read outstanding", r));
         end else if (exp_mask[r] != '0) begin
            check_val(rsp_rdata[r] & exp_mask[r], exp_data[r] & exp_mask[r],
                      $sformatf("requester %0d read of %h", r, exp_addr[r]));
         end
         pending[r] = 1'b0;
      end else if (pending[r] && cyc == due[r]) begin
         flag_protocol($sformatf("requester %0d got no rvalid one cycle after its read", r));
         pending[r] = 1'b0;
      end
   endtask

   // Responses and acceptances, sampled mid-cycle
   always @(negedge clk_i) begin
      cyc++;
      was_busy = pending[0] | pending[1];
      for (int r = 0; r < 2; r++) begin
         check_response(r);
      end
      if (rsp_ready[0] && rsp_ready[1]) begin
         flag_protocol("both requesters saw ready in the same cycle");
      end
      for (int r = 0; r < 2; r++) begin
         if (rsp_ready[r] && !req_avalid[r]) begin
            flag_protocol($sformatf("ready at requester %0d without a request", r));
         end else if (rsp_ready[r]) begin
            if (was_busy) begin
               flag_protocol($sformatf("requester %0d accepted while a read was pending", r));
            end
            // A waiting requester must not see the other one served twice
            if (req_avalid[1-r]) begin
               skip_cnt[1-r]++;
               if (skip_cnt[1-r] > 1) begin
                  flag_protocol($sformatf("requester %0d passed over twice", 1 - r));
               end
            end
            skip_cnt[r] = 0;
            apply_accept(r);
         end
      end
      for (int r = 0; r < 2; r++) begin
         if (!req_avalid[r]) begin
            skip_cnt[r] = 0;
         end
      end
   end

   initial begin
      #(TIMEOUT);
      $display("Run timed out at %0t, a requester is still waiting on the bus", $time);
      $display("=== FAIL ===");
      $finish;
   end

   initial begin
      void'($urandom(32'h24b3));
      clk_i = 1'b0;
      rst_i = 1'b1;
      for (int r = 0; r < 2; r++) begin
         req_avalid[r] = 1'b0;
         req_addr[r]   = '0;
         req_wdata[r]  = '0;
         req_wstrb[r]  = '0;
      end
      for (int w = 0; w < 2**soc_bus_pkg::RAM_AW; w++) begin
         ram_m[w]    = '0;
         ram_mask[w] = '0;
      end
      scratch_m = '{default: '0};
      wr_cnt    = '0;
      repeat (RST_CYC) @(posedge clk_i);
      #STIM_DLY;
      rst_i = 1'b0;
      // Idle bus after reset, no ready and no rvalid anywhere
      repeat (2) begin
         @(negedge clk_i);
         for (int r = 0; r < 2; r++) begin
            check_val(32'(rsp_ready[r]), '0, $sformatf("ready %0d on an idle bus", r));
            check_val(32'(rsp_rvalid[r]), '0, $sformatf("rvalid %0d on an idle bus", r));
         end
      end
      @(posedge clk_i);
      #STIM_DLY;
      // Every register reads as zero before the first write
      for (int i = 0; i < N_DIRECT; i++) begin
         drive_request(0, {1'b1, 5'd0, 8'(i), 2'd0}, '0, '0);
      end
      fork
         run_requester(0, N_REQ);
         run_requester(1, N_REQ);
      join
      repeat (3) @(posedge clk_i);
      $display("Errors: %0d data, %0d protocol, %0d assertion",
               data_errs, proto_errs, uut.chk.fail_cnt);
      if (data_errs == 0 && proto_errs == 0 && uut.chk.fail_cnt == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

//--- build.f
hdl/soc_bus_pkg.sv
hdl/iob_bus_arbiter.sv
hdl/iob_bus_demux.sv
hdl/iob_ram_sp.sv
hdl/iob_regs_ws.sv
hdl/iob_soc_bus.sv
verif/iob_bus_chk.sv
verif/tb_iob_soc_bus.sv

//--- Bender.yml
package:
  name: iob_soc_bus

sources:
  - files:
      - hdl/soc_bus_pkg.sv
      - hdl/iob_bus_arbiter.sv
      - hdl/iob_bus_demux.sv
      - hdl/iob_ram_sp.sv
      - hdl/iob_regs_ws.sv
      - hdl/iob_soc_bus.sv
  - target: test
    files:
      - verif/iob_bus_chk.sv
      - verif/tb_iob_soc_bus.sv
